// File: include/pwm_defines.svh
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// channel count and datapath widths.
`define PWM_CHANNELS    4
`define PWM_CNT_W       32
`define PWM_STEP_W      12

// register map, channel index in the upper address bits.
`define PWM_ADDR_W      5
`define PWM_CH_STRIDE   8

// field offsets inside one channel window.
`define PWM_FIELD_MODE    0
`define PWM_FIELD_PERIOD  1
`define PWM_FIELD_THR1    2
`define PWM_FIELD_THR2    3
`define PWM_FIELD_STEP    4

`endif

// File: src/pwm_pkg.sv
`default_nettype none

`include "pwm_defines.svh"

package pwm_pkg;

   // channel operating mode.
   typedef enum logic [1:0] {
      PWM_OFF      = 2'd0,
      PWM_STANDARD = 2'd1,
      PWM_BREATHE  = 2'd2,
      PWM_RESERVED = 2'd3 // acts as off.
   } pwm_mode_t;

   // word offset inside one channel window.
   typedef enum logic [2:0] {
      PWM_FLD_MODE   = `PWM_FIELD_MODE,
      PWM_FLD_PERIOD = `PWM_FIELD_PERIOD,
      PWM_FLD_THR1   = `PWM_FIELD_THR1,
      PWM_FLD_THR2   = `PWM_FIELD_THR2,
      PWM_FLD_STEP   = `PWM_FIELD_STEP
   } pwm_field_t;

endpackage

`default_nettype wire

// File: src/pwm_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

interface pwm_cfg_if;

   pwm_pkg::pwm_mode_t       mode;
   logic [`PWM_CNT_W-1:0]    period;
   logic [`PWM_CNT_W-1:0]    thr1;   // fixed duty, lower ramp bound.
   logic [`PWM_CNT_W-1:0]    thr2;   // upper ramp bound.
   logic [`PWM_STEP_W-1:0]   step;

   modport regs (
      output mode,
      output period,
      output thr1,
      output thr2,
      output step
   );

   modport chan (
      input  mode,
      input  period,
      input  thr1,
      input  thr2,
      input  step
   );

endinterface

`default_nettype wire

// File: src/pwm_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_regs (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    wr_en_i,
   input  logic                    rd_en_i,
   input  logic [`PWM_ADDR_W-1:0]  addr_i,
   input  logic [31:0]             wdata_i,
   output logic [31:0]             rdata_o,
   output logic                    rvalid_o,
   pwm_cfg_if.regs                 cfg_o [`PWM_CHANNELS]
);

   localparam int FLD_W = $clog2(`PWM_CH_STRIDE);
   localparam int CH_W  = $clog2(`PWM_CHANNELS);

   logic [CH_W-1:0]        ch_idx;
   pwm_pkg::pwm_field_t    field;

   pwm_pkg::pwm_mode_t     mode_q   [`PWM_CHANNELS];
   logic [`PWM_CNT_W-1:0]  period_q [`PWM_CHANNELS];
   logic [`PWM_CNT_W-1:0]  thr1_q   [`PWM_CHANNELS];
   logic [`PWM_CNT_W-1:0]  thr2_q   [`PWM_CHANNELS];
   logic [`PWM_STEP_W-1:0] step_q   [`PWM_CHANNELS];

   logic [31:0]            rd_mux;

   assign ch_idx = addr_i[FLD_W +: CH_W];
   assign field  = pwm_pkg::pwm_field_t'(addr_i[FLD_W-1:0]);

   // field storage, one write port shared by all channels.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < `PWM_CHANNELS; i++) begin
            mode_q[i]   <= pwm_pkg::PWM_OFF;
            period_q[i] <= '0;
            thr1_q[i]   <= '0;
            thr2_q[i]   <= '0;
            step_q[i]   <= '0;
         end
      end
      else if (wr_en_i) begin
         case (field)
            pwm_pkg::PWM_FLD_MODE: begin
               mode_q[ch_idx] <= pwm_pkg::pwm_mode_t'(wdata_i[1:0]);
            end
            pwm_pkg::PWM_FLD_PERIOD: begin
               period_q[ch_idx] <= wdata_i[`PWM_CNT_W-1:0];
            end
            pwm_pkg::PWM_FLD_THR1: begin
               thr1_q[ch_idx] <= wdata_i[`PWM_CNT_W-1:0];
            end
            pwm_pkg::PWM_FLD_THR2: begin
               thr2_q[ch_idx] <= wdata_i[`PWM_CNT_W-1:0];
            end
            pwm_pkg::PWM_FLD_STEP: begin
               step_q[ch_idx] <= wdata_i[`PWM_STEP_W-1:0];
            end
            default: begin
            end // unmapped, dropped.
         endcase
      end
   end

   // narrow fields come back zero extended.
   always_comb begin
      case (field)
         pwm_pkg::PWM_FLD_MODE:   rd_mux = 32'(mode_q[ch_idx]);
         pwm_pkg::PWM_FLD_PERIOD: rd_mux = 32'(period_q[ch_idx]);
         pwm_pkg::PWM_FLD_THR1:   rd_mux = 32'(thr1_q[ch_idx]);
         pwm_pkg::PWM_FLD_THR2:   rd_mux = 32'(thr2_q[ch_idx]);
         pwm_pkg::PWM_FLD_STEP:   rd_mux = 32'(step_q[ch_idx]);
         default:                 rd_mux = '0;
      endcase
   end

   // old value wins on a same-cycle write.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_o  <= '0;
         rvalid_o <= 1'b0;
      end
      else begin
         rvalid_o <= rd_en_i;
         if (rd_en_i) begin
            rdata_o <= rd_mux;
         end
      end
   end

   for (genvar g = 0; g < `PWM_CHANNELS; g++) begin : g_cfg
      assign cfg_o[g].mode   = mode_q[g];
      assign cfg_o[g].period = period_q[g];
      assign cfg_o[g].thr1   = thr1_q[g];
      assign cfg_o[g].thr2   = thr2_q[g];
      assign cfg_o[g].step   = step_q[g];
   end

endmodule

`default_nettype wire

// File: src/pwm_channel.sv
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_channel (
   input  logic     clk_i,
   input  logic     rst_i,
   pwm_cfg_if.chan  cfg_i,
   output logic     pwm_o
);

   logic [`PWM_CNT_W-1:0] counter_q;
   logic [`PWM_CNT_W-1:0] counter_d;
   logic [`PWM_CNT_W-1:0] thr_q;      // working threshold in breathe mode.
   logic [`PWM_CNT_W-1:0] thr_d;
   logic [`PWM_CNT_W-1:0] step_ext;
   logic [`PWM_CNT_W-1:0] thr_up;
   logic [`PWM_CNT_W-1:0] thr_dn;
   logic                  pwm_q;
   logic                  pwm_d;
   logic                  reload_q;
   logic                  reload_d;
   logic                  down_q;
   logic                  down_d;
   logic                  wrap;

   assign pwm_o = pwm_q;

   // also catches a counter left above a shortened period.
   assign wrap = (counter_q >= cfg_i.period - 1'b1);

   assign step_ext = `PWM_CNT_W'(cfg_i.step);
   assign thr_up   = thr_q + step_ext;

   // floor at zero so the bottom turn is not lost to underflow.
   assign thr_dn = (thr_q > step_ext) ? thr_q - step_ext : '0;

   always_comb begin
      counter_d = counter_q;
      thr_d     = thr_q;
      reload_d  = reload_q;
      down_d    = down_q;
      pwm_d     = 1'b0;

      case (cfg_i.mode)
         pwm_pkg::PWM_STANDARD: begin
            reload_d = 1'b1;
            if (wrap) begin
               counter_d = '0; // output low in wrap cycle.
            end
            else begin
               counter_d = counter_q + 1'b1;
               pwm_d     = (counter_q < cfg_i.thr1);
            end
         end

         pwm_pkg::PWM_BREATHE: begin
            if (reload_q) begin
               // first cycle in breathe mode.
               thr_d    = cfg_i.thr1;
               down_d   = 1'b0;
               reload_d = 1'b0;
            end
            else if (!down_q && thr_q > cfg_i.thr2) begin
               counter_d = '0; // top reached, turn down.
               thr_d     = cfg_i.thr2;
               down_d    = 1'b1;
            end
            else if (down_q && thr_q < cfg_i.thr1) begin
               counter_d = '0; // bottom reached, turn up.
               thr_d     = cfg_i.thr1;
               down_d    = 1'b0;
            end
            else if (wrap) begin
               counter_d = '0;
               thr_d     = down_q ? thr_dn : thr_up;
            end
            else begin
               counter_d = counter_q + 1'b1;
               pwm_d     = (counter_q < thr_q);
            end
         end

         default: begin
            // off and reserved, counter and direction hold.
            reload_d = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pwm_q     <= 1'b0;
         counter_q <= '0;
         thr_q     <= '0;
         reload_q  <= 1'b0;
         down_q    <= 1'b0;
      end
      else begin
         pwm_q     <= pwm_d;
         counter_q <= counter_d;
         thr_q     <= thr_d;
         reload_q  <= reload_d;
         down_q    <= down_d;
      end
   end

endmodule

`default_nettype wire

// File: src/pwm_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_top (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      wr_en_i,
   input  logic                      rd_en_i,
   input  logic [`PWM_ADDR_W-1:0]    addr_i,
   input  logic [31:0]               wdata_i,
   output logic [31:0]               rdata_o,
   output logic                      rvalid_o,
   output logic [`PWM_CHANNELS-1:0]  pwm_o
);

   // one configuration bundle per channel.
   pwm_cfg_if cfg [`PWM_CHANNELS] ();

   pwm_regs u_regs (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (wr_en_i),
      .rd_en_i  (rd_en_i),
      .addr_i   (addr_i),
      .wdata_i  (wdata_i),
      .rdata_o  (rdata_o),
      .rvalid_o (rvalid_o),
      .cfg_o    (cfg)
   );

   for (genvar g = 0; g < `PWM_CHANNELS; g++) begin : g_chan
      pwm_channel u_chan (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .cfg_i (cfg[g]),
         .pwm_o (pwm_o[g]) // registered inside the channel.
      );
   end

endmodule

`default_nettype wire

// File: sim/tb_pwm_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module tb_pwm_top;

   localparam int MAX_CYCLES = 40000;
   localparam int NUM_ADDR   = `PWM_CHANNELS * `PWM_CH_STRIDE;
   localparam int MAX_PERIOD = 40;
   localparam int BR_PERIOD  = 32;
   localparam int BR_THR1    = 4;
   localparam int BR_THR2    = 24;
   localparam int BR_STEP    = 4;
   localparam int BR_PULSES  = 14; // up, down and back up again.

   logic                     clk_i;
   logic                     rst_i;
   logic                     wr_en_i;
   logic                     rd_en_i;
   logic [`PWM_ADDR_W-1:0]   addr_i;
   logic [31:0]              wdata_i;
   logic [31:0]              rdata_o;
   logic                     rvalid_o;
   logic [`PWM_CHANNELS-1:0] pwm_o;

   int          seed;
   int          error_cnt;
   int          check_cnt;
   int          cycle_cnt;
   logic [31:0] model_regs [NUM_ADDR]; // mirror of the register map.

   pwm_top u_dut (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (wr_en_i),
      .rd_en_i  (rd_en_i),
      .addr_i   (addr_i),
      .wdata_i  (wdata_i),
      .rdata_o  (rdata_o),
      .rvalid_o (rvalid_o),
      .pwm_o    (pwm_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run still going after %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_i)
      rvalid_o |-> $past(rd_en_i))
      else begin
         error_cnt = error_cnt + 1;
         $display("error at %0t: rvalid_o high without a read strobe before it", $time);
      end

   a_read_answered: assert property (@(posedge clk_i) disable iff (!rst_i)
      rd_en_i |=> rvalid_o)
      else begin
         error_cnt = error_cnt + 1;
         $display("error at %0t: read strobe got no rvalid_o on the next cycle", $time);
      end

   a_reset_quiet: assert property (@(posedge clk_i) !rst_i |=> (pwm_o == '0 && !rvalid_o))
      else begin
         error_cnt = error_cnt + 1;
         $display("error at %0t: outputs not low while in reset", $time);
      end

   function automatic int reg_addr(input int ch, input int fld);
      return ch * `PWM_CH_STRIDE + fld;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   // bits a field keeps, unmapped offsets keep none.
   function automatic logic [31:0] field_mask(input int fld);
      case (fld)
         `PWM_FIELD_MODE:   return 32'h3;
         `PWM_FIELD_PERIOD: return 32'hffff_ffff;
         `PWM_FIELD_THR1:   return 32'hffff_ffff;
         `PWM_FIELD_THR2:   return 32'hffff_ffff;
         `PWM_FIELD_STEP:   return (32'h1 << `PWM_STEP_W) - 1;
         default:           return 32'h0;
      endcase
   endfunction

   // high cycles per period, standard mode only.
   function automatic int expected_high(input int ch);
      logic [31:0] mode;
      logic [31:0] per;
      logic [31:0] thr1;
      mode = model_regs[reg_addr(ch, `PWM_FIELD_MODE)];
      per  = model_regs[reg_addr(ch, `PWM_FIELD_PERIOD)];
      thr1 = model_regs[reg_addr(ch, `PWM_FIELD_THR1)];
      if (mode != 32'(pwm_pkg::PWM_STANDARD)) begin
         return 0;
      end
      return (thr1 < per - 1) ? int'(thr1) : int'(per - 1);
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      assert (act === exp)
      else begin
         error_cnt++;
         $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      check_cnt++;
      assert (cond)
      else begin
         error_cnt++;
         $display("error at %0t: %s", $time, what);
      end
   endtask

   task automatic reg_write(input int ch, input int fld, input logic [31:0] data);
      @(posedge clk_i);
      wr_en_i <= 1'b1;
      addr_i  <= `PWM_ADDR_W'(reg_addr(ch, fld));
      wdata_i <= data;
      @(posedge clk_i);
      wr_en_i <= 1'b0;
      model_regs[reg_addr(ch, fld)] = data & field_mask(fld);
   endtask

   task automatic reg_read(input int ch, input int fld);
      int wait_cnt;
      wait_cnt = 0;
      @(posedge clk_i);
      rd_en_i <= 1'b1;
      addr_i  <= `PWM_ADDR_W'(reg_addr(ch, fld));
      @(posedge clk_i);
      rd_en_i <= 1'b0;
      @(negedge clk_i);
      while (!rvalid_o && wait_cnt < 4) begin
         @(negedge clk_i);
         wait_cnt++;
      end
      check_true(rvalid_o, $sformatf("read of ch%0d field %0d never answered", ch, fld));
      check_eq($sformatf("rdata_o ch%0d field %0d", ch, fld),
               model_regs[reg_addr(ch, fld)], rdata_o);
   endtask

   // one period per channel, all channels in the same window.
   task automatic measure_duty();
      int cnt [`PWM_CHANNELS];
      int win;
      int per;
      win = 0;
      for (int c = 0; c < `PWM_CHANNELS; c++) begin
         cnt[c] = 0;
         per = model_regs[reg_addr(c, `PWM_FIELD_PERIOD)];
         if (per > win) begin
            win = per;
         end
      end
      for (int i = 0; i < win; i++) begin
         @(negedge clk_i);
         for (int c = 0; c < `PWM_CHANNELS; c++) begin
            if (i < int'(model_regs[reg_addr(c, `PWM_FIELD_PERIOD)]) && pwm_o[c]) begin
               cnt[c]++;
            end
            if (model_regs[reg_addr(c, `PWM_FIELD_MODE)] != 32'(pwm_pkg::PWM_STANDARD)) begin
               check_true(!pwm_o[c], $sformatf("pwm_o[%0d] high while channel is off", c));
            end
         end
      end
      for (int c = 0; c < `PWM_CHANNELS; c++) begin
         check_eq($sformatf("pwm_o[%0d] high count", c), expected_high(c), cnt[c]);
      end
   endtask

   task automatic check_pulses(input int ch);
      int  run;
      int  seen;
      int  guard;
      int  prev;
      int  t;
      int  exp;
      bit  up;
      bit  fell;
      bit  rose;
      run = 0;
      seen = 0;
      guard = 0;
      prev = -1;
      t = BR_THR1;
      up = 1'b1;
      fell = 1'b0;
      rose = 1'b0;
      while (seen < BR_PULSES && guard < (BR_PULSES + 2) * (BR_PERIOD + 2)) begin
         @(negedge clk_i);
         guard++;
         if (pwm_o[ch]) begin
            run++;
         end
         else if (run > 0) begin
            exp = (t < BR_PERIOD - 1) ? t : BR_PERIOD - 1;
            check_eq($sformatf("pwm_o[%0d] pulse %0d", ch, seen), exp, run);
            check_true(run <= BR_THR2 + BR_STEP, "breathe pulse above upper bound");
            check_true(run >= BR_THR1, "breathe pulse below lower bound");
            if (prev >= 0 && run < prev) fell = 1'b1;
            if (fell && prev >= 0 && run > prev) rose = 1'b1;
            prev = run;
            run = 0;
            seen++;
            if (up) begin
               t = t + BR_STEP;
               if (t > BR_THR2) begin
                  t = BR_THR2; // turns at the top.
                  up = 1'b0;
               end
            end
            else begin
               t = t - BR_STEP;
               if (t < BR_THR1) begin
                  t = BR_THR1;
                  up = 1'b1;
               end
            end
         end
      end
      check_true(seen == BR_PULSES, "breathe output stopped pulsing");
      check_true(fell && rose, "breathe ramp did not go down and back up");
   endtask

   task automatic breathe_ramp(input int ch);
      reg_write(ch, `PWM_FIELD_PERIOD, 32'd1); // parks the counter at zero.
      reg_write(ch, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_STANDARD));
      repeat (3) @(posedge clk_i);
      reg_write(ch, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_OFF));
      reg_write(ch, `PWM_FIELD_PERIOD, BR_PERIOD);
      reg_write(ch, `PWM_FIELD_THR1, BR_THR1);
      reg_write(ch, `PWM_FIELD_THR2, BR_THR2);
      reg_write(ch, `PWM_FIELD_STEP, BR_STEP);
      reg_write(ch, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_BREATHE));
      check_pulses(ch);
   endtask

   initial begin
      int per;
      int thr;
      clk_i = 1'b0;
      rst_i = 1'b0;
      wr_en_i = 1'b0;
      rd_en_i = 1'b0;
      addr_i = '0;
      wdata_i = '0;
      seed = 76;
      error_cnt = 0;
      check_cnt = 0;
      cycle_cnt = 0;
      for (int a = 0; a < NUM_ADDR; a++) begin
         model_regs[a] = '0;
      end
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b1;

      @(negedge clk_i);
      check_eq("pwm_o", '0, pwm_o);
      check_eq("rvalid_o", '0, rvalid_o);
      for (int c = 0; c < `PWM_CHANNELS; c++) begin
         for (int f = 0; f <= `PWM_FIELD_STEP; f++) reg_read(c, f);
      end

      // every offset, unmapped ones too.
      for (int c = 0; c < `PWM_CHANNELS; c++) begin
         for (int f = 0; f < `PWM_CH_STRIDE; f++) reg_write(c, f, $random(seed));
      end
      for (int c = 0; c < `PWM_CHANNELS; c++) begin
         for (int f = 0; f < `PWM_CH_STRIDE; f++) reg_read(c, f);
      end

      for (int round = 0; round < 2; round++) begin
         for (int c = 0; c < `PWM_CHANNELS; c++) begin
            per = rand_range(8, MAX_PERIOD);
            if (round == 1) thr = rand_range(0, per + 4);
            else if (c == 0) thr = 0;
            else if (c == 1) thr = per + rand_range(0, 10);
            else if (c == 2) thr = per - 1;
            else thr = rand_range(1, per - 2);
            reg_write(c, `PWM_FIELD_PERIOD, per);
            reg_write(c, `PWM_FIELD_THR1, thr);
            reg_write(c, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_STANDARD));
         end
         repeat (2 * MAX_PERIOD + 4) @(posedge clk_i);
         repeat (3) measure_duty();
      end

      reg_write(1, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_OFF));
      reg_write(2, `PWM_FIELD_MODE, 32'(pwm_pkg::PWM_RESERVED));
      @(posedge clk_i);
      repeat (3) measure_duty();

      breathe_ramp(1);

      $display("errors: %0d, checks: %0d", error_cnt, check_cnt);
      if (error_cnt == 0) begin
         $display("Testbench passed");
      end
      else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
src/pwm_pkg.sv
src/pwm_cfg_if.sv
src/pwm_regs.sv
src/pwm_channel.sv
src/pwm_top.sv
sim/tb_pwm_top.sv
